//--- tb.f
+incdir+include
source/vpu_pkg.sv
source/vpu_issue.sv
source/vpu_regfile.sv
source/vpu_lane.sv
source/vpu_rf_ctrl.sv
source/vpu_top.sv
bench/vpu_properties.sv
bench/vpu_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = vpu_tb
FILELIST  = tb.f
OBJ_DIR   = obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "RESULT: PASS"

clean:
	rm -rf $(OBJ_DIR)

//--- bench/vpu_tb.sv
// ######################################
// VPU testbench
// Directed and random vector tests against a register-file model
// ######################################
`timescale 1ns/100ps
`include "vpu_params.svh"

module vpu_tb;

    localparam int PERIOD       = 40;
    localparam int TIMEOUT      = 50;
    localparam int SEED         = 59;
    localparam int LANES        = `VPU_LANES;
    localparam int REGS         = `VPU_NUM_REGS;
    localparam int ACCEPT_TO_WB = 3;

    logic                clk;
    logic                rst_n;
    logic                flush;
    logic                instr_req;
    vpu_pkg::vpu_instr_t instr;
    logic                instr_ack;
    logic                int_wr_valid;
    vpu_pkg::vpu_elem_t  int_wr_data;

    vpu_pkg::vpu_vec_t   model_rf [REGS];
    vpu_pkg::vpu_elem_t  pulse_data_q [$];
    int                  pulse_cyc_q [$];
    int                  cycle;
    int                  errors;
    int                  checks;
    int                  tests;

    vpu_top u_dut (
        .clk(clk), .rst_n(rst_n), .flush(flush),
        .instr_req(instr_req), .instr(instr), .instr_ack(instr_ack),
        .int_wr_valid(int_wr_valid), .int_wr_data(int_wr_data)
    );

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("Timeout at %0t: %s", $time, why);
        $display("RESULT: FAIL");
        $finish;
    endtask

    task automatic compare_value(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("[ERROR] %0t %s: got 0x%0h, expected 0x%0h", $time, name, got, exp);
        end
    endtask

    task automatic finish_test(input string name, input int e0);
        tests++;
        $display("test %-9s %s (%0d errors)", name, (errors == e0) ? "ok" : "failed",
                 errors - e0);
    endtask

    // Advance to the falling edge and log any scalar pulse with its cycle
    task automatic tick();
        @(negedge clk);
        cycle++;
        if (int_wr_valid) begin
            pulse_data_q.push_back(int_wr_data);
            pulse_cyc_q.push_back(cycle);
        end
    endtask

    task automatic send_instr(input vpu_pkg::vpu_instr_t ins, input logic with_flush,
                              output int ack_cyc);
        int n;
        ack_cyc = 0;
        @(posedge clk);
        instr     <= ins;
        instr_req <= 1'b1;
        n = 0;
        tick();
        while (!instr_ack && n < TIMEOUT) begin
            tick();
            n++;
        end
        if (!instr_ack) begin
            abort_run("instr_ack never rose for a pending request");
        end else begin
            ack_cyc = cycle;
            @(posedge clk);
            instr_req <= 1'b0;
            flush     <= with_flush;
            tick();
            @(posedge clk);
            flush <= 1'b0;
            n = 0;
            tick();
            while (instr_ack && n < TIMEOUT) begin
                tick();
                n++;
            end
            if (instr_ack) begin
                abort_run("instr_ack stayed high after instr_req dropped");
            end
        end
    endtask

    task automatic model_apply(input vpu_pkg::vpu_instr_t ins);
        vpu_pkg::vpu_vec_t  src2;
        vpu_pkg::vpu_vec_t  src1;
        vpu_pkg::vpu_elem_t res;
        logic [1:0]         li;
        src2 = model_rf[ins.vs2];
        src1 = model_rf[ins.vs1];
        for (int i = 0; i < LANES; i++) begin
            li = 2'(i);
            case (ins.op)
                vpu_pkg::VADD_VV: res = src2[li] + src1[li];
                vpu_pkg::VSUB_VV: res = src2[li] - src1[li];
                vpu_pkg::VAND_VV: res = src2[li] & src1[li];
                vpu_pkg::VOR_VV:  res = src2[li] | src1[li];
                vpu_pkg::VADD_VX: res = src2[li] + ins.scalar;
                vpu_pkg::VMV_VX:  res = ins.scalar;
                vpu_pkg::VID:     res = 16'(i);
                default:          res = model_rf[ins.vd][li];
            endcase
            // Masked-off lanes keep their old value
            if (ins.op != vpu_pkg::VEXT && (!ins.vm || model_rf[0][li][0])) begin
                model_rf[ins.vd][li] = res;
            end
        end
    endtask

    task automatic exec_op(input vpu_pkg::vpu_op_e op, input int vd, input int vs1,
                           input int vs2, input logic vm, input vpu_pkg::vpu_elem_t scalar);
        vpu_pkg::vpu_instr_t ins;
        int                  ack_cyc;
        ins        = '0;
        ins.op     = op;
        ins.vd     = 3'(vd);
        ins.vs1    = 3'(vs1);
        ins.vs2    = 3'(vs2);
        ins.vm     = vm;
        ins.scalar = scalar;
        send_instr(ins, 1'b0, ack_cyc);
        model_apply(ins);
    endtask

    task automatic read_elem(input vpu_pkg::vpu_addr_t r, input logic [1:0] lane);
        vpu_pkg::vpu_instr_t ins;
        vpu_pkg::vpu_elem_t  got;
        int                  ack_cyc;
        int                  pulse_cyc;
        int                  n;
        ins        = '0;
        ins.op     = vpu_pkg::VEXT;
        ins.vs1    = r;
        ins.vs2    = r;
        ins.scalar = 16'hA5A4 | 16'(lane);
        send_instr(ins, 1'b0, ack_cyc);
        n = 0;
        while (pulse_data_q.size() == 0 && n < TIMEOUT) begin
            tick();
            n++;
        end
        if (pulse_data_q.size() == 0) begin
            abort_run("no scalar result arrived for VEXT");
        end else begin
            got       = pulse_data_q.pop_front();
            pulse_cyc = pulse_cyc_q.pop_front();
            compare_value($sformatf("int_wr_data v%0d[%0d]", r, lane), 64'(got),
                          64'(model_rf[r][2'(ins.scalar % LANES)]));
            // WB cycle ends 3 edges after the accept edge
            compare_value("scalar latency", 64'(pulse_cyc + 1 - ack_cyc), 64'(ACCEPT_TO_WB));
        end
    endtask

    task automatic read_reg(input int r);
        for (int l = 0; l < LANES; l++) begin
            read_elem(3'(r), 2'(l));
        end
    endtask

    task automatic test_reset();
        int e0;
        e0 = errors;
        tick();
        compare_value("instr_ack", 64'(instr_ack), 64'd0);
        compare_value("int_wr_valid", 64'(int_wr_valid), 64'd0);
        compare_value("exe_wr.lane_en", 64'(u_dut.exe_wr.lane_en), 64'd0);
        compare_value("wb_wr.lane_en", 64'(u_dut.wb_wr.lane_en), 64'd0);
        for (int r = 0; r < REGS; r++) begin
            read_elem(3'(r), 2'(r));
        end
        finish_test("reset", e0);
    endtask

    task automatic test_move_id();
        int e0;
        e0 = errors;
        exec_op(vpu_pkg::VMV_VX, 1, 0, 0, 1'b0, 16'h1234);
        exec_op(vpu_pkg::VID, 2, 0, 0, 1'b0, 16'h0000);
        read_reg(1);
        read_reg(2);
        finish_test("move_id", e0);
    endtask

    task automatic test_dependent();
        int e0;
        e0 = errors;
        exec_op(vpu_pkg::VADD_VV, 3, 1, 2, 1'b0, 16'h0000);
        exec_op(vpu_pkg::VSUB_VV, 4, 2, 3, 1'b0, 16'h0000);
        exec_op(vpu_pkg::VAND_VV, 5, 3, 4, 1'b0, 16'h0000);
        exec_op(vpu_pkg::VOR_VV, 6, 1, 5, 1'b0, 16'h0000);
        exec_op(vpu_pkg::VADD_VX, 3, 0, 6, 1'b0, 16'h0101);
        for (int r = 3; r <= 6; r++) begin
            read_reg(r);
        end
        finish_test("dependent", e0);
    endtask

    task automatic test_mask();
        int e0;
        e0 = errors;
        // v0 becomes 0,1,0,1 so odd lanes are enabled
        exec_op(vpu_pkg::VMV_VX, 7, 0, 0, 1'b0, 16'h0001);
        exec_op(vpu_pkg::VID, 0, 0, 0, 1'b0, 16'h0000);
        exec_op(vpu_pkg::VAND_VV, 0, 7, 0, 1'b0, 16'h0000);
        exec_op(vpu_pkg::VMV_VX, 5, 0, 0, 1'b1, 16'hBEEF);
        exec_op(vpu_pkg::VADD_VV, 6, 1, 6, 1'b1, 16'h0000);
        read_reg(0);
        read_reg(5);
        read_reg(6);
        finish_test("mask", e0);
    endtask

    task automatic test_flush();
        vpu_pkg::vpu_instr_t ins;
        int                  ack_cyc;
        int                  e0;
        e0         = errors;
        ins        = '0;
        ins.op     = vpu_pkg::VMV_VX;
        ins.vd     = 3'd4;
        ins.scalar = 16'hDEAD;
        send_instr(ins, 1'b1, ack_cyc);
        ins.op  = vpu_pkg::VEXT;
        ins.vs1 = 3'd4;
        ins.vs2 = 3'd4;
        send_instr(ins, 1'b1, ack_cyc);
        // Watch a few idle cycles for a stray pulse
        for (int n = 0; n < 8; n++) begin
            tick();
        end
        compare_value("scalar pulses after flush", 64'(pulse_data_q.size()), 64'd0);
        pulse_data_q.delete();
        pulse_cyc_q.delete();
        read_reg(4);
        finish_test("flush", e0);
    endtask

    task automatic test_random();
        int e0;
        e0 = errors;
        for (int k = 0; k < 20; k++) begin
            exec_op(vpu_pkg::vpu_op_e'(3'($urandom_range(0, 6))), $urandom_range(0, 7),
                    $urandom_range(0, 7), $urandom_range(0, 7), 1'($urandom_range(0, 1)),
                    16'($urandom));
        end
        for (int r = 0; r < REGS; r++) begin
            read_reg(r);
        end
        finish_test("random", e0);
    endtask

    initial begin
        int seed_val;
        seed_val  = $urandom(SEED);
        rst_n     = 1'b0;
        flush     = 1'b0;
        instr_req = 1'b0;
        instr     = '0;
        cycle     = 0;
        errors    = 0;
        checks    = 0;
        tests     = 0;
        for (int r = 0; r < REGS; r++) begin
            model_rf[r] = '0;
        end
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        test_reset();
        test_move_id();
        test_dependent();
        test_mask();
        test_flush();
        test_random();
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- bench/vpu_properties.sv
// ######################################
// VPU handshake and flush properties
// Four-phase ordering and scalar pulse after flush
// ######################################
`timescale 1ns/100ps

module vpu_properties (
    input logic clk,
    input logic rst_n,
    input logic flush,
    input logic instr_req,
    input logic instr_ack,
    input logic int_wr_valid
);

    // Ack only rises after a request was seen at the accept edge
    ack_rise_needs_req: assert property (
        @(posedge clk) disable iff (!rst_n) $rose(instr_ack) |-> $past(instr_req)
    ) else $error("instr_ack rose while instr_req was low");

    ack_held_while_req: assert property (
        @(posedge clk) disable iff (!rst_n) (instr_ack && instr_req) |=> instr_ack
    ) else $error("instr_ack fell while instr_req was still high");

    // No scalar pulse in the cycle after a flush
    flush_kills_pulse: assert property (
        @(posedge clk) disable iff (!rst_n) flush |=> !int_wr_valid
    ) else $error("int_wr_valid high in the cycle after a flush");

endmodule

bind vpu_top vpu_properties u_properties (
    .clk(clk),
    .rst_n(rst_n),
    .flush(flush),
    .instr_req(instr_req),
    .instr_ack(instr_ack),
    .int_wr_valid(int_wr_valid)
);

//--- source/vpu_top.sv
// ######################################
// VPU top
// Issue, register file, lane array and stage control
// ######################################
`timescale 1ns/100ps
`include "vpu_params.svh"

module vpu_top (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                flush,
    input  logic                instr_req,
    input  vpu_pkg::vpu_instr_t instr,
    output logic                instr_ack,
    output logic                int_wr_valid,
    output vpu_pkg::vpu_elem_t  int_wr_data
);

    vpu_pkg::vpu_instr_t id_instr;
    logic                id_valid;
    vpu_pkg::vpu_vec_t   rd_data_a;
    vpu_pkg::vpu_vec_t   rd_data_b;
    vpu_pkg::vpu_vec_t   rd_v0;
    vpu_pkg::vpu_op_e    exe_op;
    logic                exe_vm;
    vpu_pkg::vpu_mask_t  exe_mask;
    vpu_pkg::vpu_vec_t   exe_srca;
    vpu_pkg::vpu_vec_t   exe_srcb;
    vpu_pkg::vpu_elem_t  exe_scalar;
    vpu_pkg::vpu_vec_t   exe_result;
    vpu_pkg::vpu_mask_t  exe_lane_en;
    vpu_pkg::vpu_wr_t    exe_wr;
    vpu_pkg::vpu_wr_t    wb_wr;
    vpu_pkg::vpu_vec_t   wb_data;

    vpu_issue u_issue (
        .clk(clk), .rst_n(rst_n), .flush(flush),
        .instr_req(instr_req), .instr(instr), .instr_ack(instr_ack),
        .exe_wr(exe_wr), .id_instr(id_instr), .id_valid(id_valid)
    );

    // Port a reads vs2, port b reads vs1
    vpu_regfile u_regfile (
        .clk(clk), .rst_n(rst_n),
        .rd_addr_a(id_instr.vs2), .rd_addr_b(id_instr.vs1),
        .rd_data_a(rd_data_a), .rd_data_b(rd_data_b), .rd_v0(rd_v0),
        .wr(wb_wr), .wr_data(wb_data)
    );

    vpu_rf_ctrl u_rf_ctrl (
        .clk(clk), .rst_n(rst_n), .flush(flush),
        .id_instr(id_instr), .id_valid(id_valid),
        .rd_data_a(rd_data_a), .rd_data_b(rd_data_b), .rd_v0(rd_v0),
        .exe_op(exe_op), .exe_vm(exe_vm), .exe_mask(exe_mask),
        .exe_srca(exe_srca), .exe_srcb(exe_srcb), .exe_scalar(exe_scalar),
        .exe_result(exe_result), .exe_lane_en(exe_lane_en), .exe_wr(exe_wr),
        .wb_wr(wb_wr), .wb_data(wb_data),
        .int_wr_valid(int_wr_valid), .int_wr_data(int_wr_data)
    );

    for (genvar i = 0; i < `VPU_LANES; i++) begin : g_lane
        vpu_lane u_lane (
            .op(exe_op), .vm(exe_vm), .mask_bit(exe_mask[i]), .lane_idx(2'(i)),
            .a(exe_srca[i]), .b(exe_srcb[i]), .scalar(exe_scalar),
            .result(exe_result[i]), .wr_en(exe_lane_en[i])
        );
    end

endmodule

//--- source/vpu_rf_ctrl.sv
// ######################################
// VPU register file control
// ID/EXE and MEM/WB staging, VEXT element extraction
// ######################################
`timescale 1ns/100ps
`include "vpu_params.svh"

module vpu_rf_ctrl (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                flush,
    input  vpu_pkg::vpu_instr_t id_instr,
    input  logic                id_valid,
    input  vpu_pkg::vpu_vec_t   rd_data_a,
    input  vpu_pkg::vpu_vec_t   rd_data_b,
    input  vpu_pkg::vpu_vec_t   rd_v0,
    output vpu_pkg::vpu_op_e    exe_op,
    output logic                exe_vm,
    output vpu_pkg::vpu_mask_t  exe_mask,
    output vpu_pkg::vpu_vec_t   exe_srca,
    output vpu_pkg::vpu_vec_t   exe_srcb,
    output vpu_pkg::vpu_elem_t  exe_scalar,
    input  vpu_pkg::vpu_vec_t   exe_result,
    input  vpu_pkg::vpu_mask_t  exe_lane_en,
    output vpu_pkg::vpu_wr_t    exe_wr,
    output vpu_pkg::vpu_wr_t    wb_wr,
    output vpu_pkg::vpu_vec_t   wb_data,
    output logic                int_wr_valid,
    output vpu_pkg::vpu_elem_t  int_wr_data
);

    localparam int IDX_W = $clog2(`VPU_LANES);

    logic               exe_valid;
    logic               exe_sc_wr;
    vpu_pkg::vpu_addr_t exe_vd;
    vpu_pkg::vpu_mask_t id_mask;
    vpu_pkg::vpu_elem_t exe_ext;

    // Bit 0 of each v0 element
    always_comb begin
        for (int i = 0; i < `VPU_LANES; i++) begin
            id_mask[i] = rd_v0[i][0];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            exe_valid <= 1'b0;
            exe_sc_wr <= 1'b0;
        end else if (flush) begin
            exe_valid <= 1'b0;
            exe_sc_wr <= 1'b0;
        end else begin
            exe_valid <= id_valid && (id_instr.op != vpu_pkg::VEXT);
            exe_sc_wr <= id_valid && (id_instr.op == vpu_pkg::VEXT);
        end
    end

    always_ff @(posedge clk) begin
        exe_op     <= id_instr.op;
        exe_vm     <= id_instr.vm;
        exe_scalar <= id_instr.scalar;
        exe_vd     <= id_instr.vd;
        exe_srca   <= rd_data_a;
        exe_srcb   <= rd_data_b;
        exe_mask   <= id_mask;
    end

    assign exe_wr  = '{lane_en: (exe_valid ? exe_lane_en : '0), addr: exe_vd};
    assign exe_ext = exe_srca[exe_scalar[IDX_W-1:0]];

    // MEM/WB register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_wr        <= '0;
            int_wr_valid <= 1'b0;
        end else if (flush) begin
            wb_wr        <= '0;
            int_wr_valid <= 1'b0;
        end else begin
            wb_wr        <= exe_wr;
            int_wr_valid <= exe_sc_wr;
        end
    end

    always_ff @(posedge clk) begin
        wb_data     <= exe_result;
        int_wr_data <= exe_ext;
    end

endmodule

//--- source/vpu_lane.sv
// ######################################
// VPU lane
// One element ALU and its masked write enable
// ######################################
`timescale 1ns/100ps

module vpu_lane (
    input  vpu_pkg::vpu_op_e   op,
    input  logic               vm,
    input  logic               mask_bit,
    input  logic [1:0]         lane_idx,
    input  vpu_pkg::vpu_elem_t a,
    input  vpu_pkg::vpu_elem_t b,
    input  vpu_pkg::vpu_elem_t scalar,
    output vpu_pkg::vpu_elem_t result,
    output logic               wr_en
);

    // a carries vs2, b carries vs1
    always_comb begin
        case (op)
            vpu_pkg::VADD_VV: result = a + b;
            vpu_pkg::VSUB_VV: result = a - b;
            vpu_pkg::VAND_VV: result = a & b;
            vpu_pkg::VOR_VV:  result = a | b;
            vpu_pkg::VADD_VX: result = a + scalar;
            vpu_pkg::VMV_VX:  result = scalar;
            vpu_pkg::VID:     result = vpu_pkg::vpu_elem_t'(lane_idx);
            default:          result = a;
        endcase
    end

    // Extract never writes the vector file
    assign wr_en = (op != vpu_pkg::VEXT) && (!vm || mask_bit);

endmodule

//--- source/vpu_regfile.sv
// ######################################
// VPU vector register file
// Two source reads, v0 read, lane-masked write with bypass
// ######################################
`timescale 1ns/100ps
`include "vpu_params.svh"

module vpu_regfile (
    input  logic              clk,
    input  logic              rst_n,
    input  vpu_pkg::vpu_addr_t rd_addr_a,
    input  vpu_pkg::vpu_addr_t rd_addr_b,
    output vpu_pkg::vpu_vec_t  rd_data_a,
    output vpu_pkg::vpu_vec_t  rd_data_b,
    output vpu_pkg::vpu_vec_t  rd_v0,
    input  vpu_pkg::vpu_wr_t   wr,
    input  vpu_pkg::vpu_vec_t  wr_data
);

    vpu_pkg::vpu_vec_t regs [`VPU_NUM_REGS];
    vpu_pkg::vpu_vec_t wr_merged;
    logic              wr_any;

    // Old contents with the enabled lanes replaced
    always_comb begin
        wr_merged = regs[wr.addr];
        for (int i = 0; i < `VPU_LANES; i++) begin
            if (wr.lane_en[i]) begin
                wr_merged[i] = wr_data[i];
            end
        end
    end

    assign wr_any = |wr.lane_en;

    // WB write is visible to reads in the same cycle
    assign rd_data_a = (wr_any && (wr.addr == rd_addr_a)) ? wr_merged : regs[rd_addr_a];
    assign rd_data_b = (wr_any && (wr.addr == rd_addr_b)) ? wr_merged : regs[rd_addr_b];
    assign rd_v0     = (wr_any && (wr.addr == '0)) ? wr_merged : regs[0];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int r = 0; r < `VPU_NUM_REGS; r++) begin
                regs[r] <= '0;
            end
        end else if (wr_any) begin
            regs[wr.addr] <= wr_merged;
        end
    end

endmodule

//--- source/vpu_issue.sv
// ######################################
// VPU issue unit
// Four-phase instruction intake, RAW hazard hold and ID register
// ######################################
`timescale 1ns/100ps

module vpu_issue (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                flush,
    input  logic                instr_req,
    input  vpu_pkg::vpu_instr_t instr,
    output logic                instr_ack,
    input  vpu_pkg::vpu_wr_t    exe_wr,
    output vpu_pkg::vpu_instr_t id_instr,
    output logic                id_valid
);

    typedef enum logic {
        IDLE,
        WAIT_DROP
    } state_e;

    state_e state;
    logic   id_wr;
    logic   hazard;
    logic   accept;

    // Does the candidate read register d
    function automatic logic reads_reg(vpu_pkg::vpu_instr_t c, vpu_pkg::vpu_addr_t d);
        return (c.vs1 == d) || (c.vs2 == d) || (c.vm && (d == '0));
    endfunction

    assign id_wr = id_valid && (id_instr.op != vpu_pkg::VEXT);

    assign hazard = (id_wr && reads_reg(instr, id_instr.vd)) ||
                    ((|exe_wr.lane_en) && reads_reg(instr, exe_wr.addr));

    assign accept = (state == IDLE) && instr_req && !hazard && !flush;

    assign instr_ack = (state == WAIT_DROP);

    // Handshake sequencing
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (accept) begin
                        state <= WAIT_DROP;
                    end
                end
                WAIT_DROP: begin
                    if (!instr_req) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // One-cycle valid per accepted instruction
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            id_valid <= 1'b0;
        end else begin
            id_valid <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            id_instr <= instr;
        end
    end

endmodule

//--- source/vpu_pkg.sv
// ######################################
// VPU package
// Opcodes, element and vector types, instruction and write-back structs
// ######################################
`include "vpu_params.svh"

package vpu_pkg;

    typedef logic [$clog2(`VPU_NUM_REGS)-1:0] vpu_addr_t;
    typedef logic [`VPU_ELEM_W-1:0] vpu_elem_t;
    typedef logic [`VPU_LANES-1:0][`VPU_ELEM_W-1:0] vpu_vec_t;
    typedef logic [`VPU_LANES-1:0] vpu_mask_t;

    typedef enum logic [2:0] {
        VADD_VV = 3'd0,
        VSUB_VV = 3'd1,
        VAND_VV = 3'd2,
        VOR_VV  = 3'd3,
        VADD_VX = 3'd4,
        VMV_VX  = 3'd5,
        VID     = 3'd6,
        VEXT    = 3'd7
    } vpu_op_e;

    // vm set means masked by bit 0 of each v0 element
    typedef struct packed {
        vpu_op_e   op;
        vpu_addr_t vd;
        vpu_addr_t vs1;
        vpu_addr_t vs2;
        logic      vm;
        vpu_elem_t scalar;
    } vpu_instr_t;

    typedef struct packed {
        vpu_mask_t lane_en;
        vpu_addr_t addr;
    } vpu_wr_t;

endpackage

//--- include/vpu_params.svh
// ######################################
// VPU parameters
// Lane count, element width and size of the vector register file
// ######################################
`ifndef VPU_PARAMS_SVH
`define VPU_PARAMS_SVH

`define VPU_LANES     4
`define VPU_ELEM_W    16
`define VPU_NUM_REGS  8

`endif
